// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cmd_buffer
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
PASS_MSG  := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: build.f
hw/cmd_pkg.sv
hw/bus_pkg.sv
hw/cmd_bus_slave.sv
hw/cmd_loader.sv
hw/cmd_debug_reader.sv
hw/cmd_sequencer.sv
hw/cmd_mem_arbiter.sv
hw/cmd_store.sv
hw/cmd_buffer_top.sv
testbench/tb_cmd_buffer.sv

// File: hw/bus_pkg.sv
// Register bus structs, address map, status word layout and executor credit sizing
package bus_pkg;

    typedef logic [9:0]  bus_addr_t;           // Word address
    typedef logic [31:0] bus_data_t;           // Bus word
    typedef logic [2:0]  credit_t;             // Executor credit counter

    typedef struct packed {
        logic      valid;                      // Transfer requested
        logic      write;                      // 1 write, 0 read
        bus_addr_t addr;
        bus_data_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic      rvalid;                     // Read data valid
        bus_data_t rdata;
    } bus_rsp_t;

    // ------------------------------------------------------------
    // Address map
    localparam bus_addr_t PUSH_ADDR   = 10'h000; // Command word push
    localparam bus_addr_t CTRL_ADDR   = 10'h001; // Control pulses
    localparam bus_addr_t STATUS_ADDR = 10'h002; // Read-only status
    localparam bus_addr_t DBG_BASE    = 10'h100; // 2 words per slot

    localparam int CTRL_COMMIT  = 0;           // Close the list
    localparam int CTRL_START   = 1;           // Run the sequencer
    localparam int CTRL_CLR_ERR = 2;           // Drop the error flag

    typedef struct packed {
        logic [20:0] rsvd;                     // Reads as zero
        logic        error;                    // Bit 10
        logic        busy;                     // Bit 9
        logic        committed;                // Bit 8
        logic [7:0]  count;                    // Bits 7..0
    } status_t;

    localparam credit_t EXEC_CREDITS = 3'd4;   // Credits held after reset

endpackage

// File: hw/cmd_buffer_top.sv
// Command buffer top level, ties the bus slave, the three memory peers, the arbiter and the store
module cmd_buffer_top (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t bus_req,
    output logic              bus_ready,
    output bus_pkg::bus_rsp_t bus_rsp,
    output logic              exec_valid,
    output cmd_pkg::cmd_t     exec_cmd,
    input  logic              credit_return
);
    import cmd_pkg::*;
    import bus_pkg::*;

    // ------------------------------------------------------------
    // Bus slave to peers
    logic      push, push_ready, commit, clear_err, start;
    bus_data_t push_word;
    logic      dbg_req, dbg_half, dbg_done;
    cmd_idx_t  dbg_idx;
    bus_data_t dbg_data;
    cmd_cnt_t  count;
    logic      committed, error, busy;

    // Peers to arbiter to store
    mem_req_t  req_load, req_dbg, req_seq, store_req;
    mem_rsp_t  rsp_load, rsp_dbg, rsp_seq, store_rsp;
    logic      gnt_load, gnt_dbg, gnt_seq;

    cmd_bus_slave cmd_bus_slave_i (
        .clk, .rst_n, .bus_req, .bus_ready, .bus_rsp,
        .push, .push_word, .push_ready, .commit, .clear_err, .start,
        .dbg_req, .dbg_idx, .dbg_half, .dbg_done, .dbg_data,
        .count, .committed, .error, .busy
    );

    cmd_loader cmd_loader_i (
        .clk, .rst_n, .push, .push_word, .push_ready, .commit, .clear_err, .busy,
        .mem_req (req_load),
        .mem_gnt (gnt_load),
        .count, .committed, .error
    );

    cmd_debug_reader cmd_debug_reader_i (
        .clk, .rst_n, .dbg_req, .dbg_idx, .dbg_half,
        .mem_req (req_dbg),
        .mem_gnt (gnt_dbg),
        .mem_rsp (rsp_dbg),
        .dbg_done, .dbg_data
    );

    cmd_sequencer cmd_sequencer_i (
        .clk, .rst_n, .start, .committed, .count,
        .mem_req (req_seq),
        .mem_gnt (gnt_seq),
        .mem_rsp (rsp_seq),
        .exec_valid, .exec_cmd, .credit_return, .busy
    );

    cmd_mem_arbiter cmd_mem_arbiter_i (
        .clk, .rst_n, .req_load, .req_dbg, .req_seq,
        .gnt_load, .gnt_dbg, .gnt_seq, .rsp_load, .rsp_dbg, .rsp_seq,
        .store_req, .store_rsp
    );

    cmd_store cmd_store_i (
        .clk, .rst_n,
        .req (store_req),
        .rsp (store_rsp)
    );

endmodule

// File: hw/cmd_bus_slave.sv
// Register bus front end that decodes transfers into peer pulses and returns read responses
module cmd_bus_slave (
    input  logic              clk,
    input  logic              rst_n,
    input  bus_pkg::bus_req_t bus_req,
    output logic              bus_ready,
    output bus_pkg::bus_rsp_t bus_rsp,
    output logic              push,
    output bus_pkg::bus_data_t push_word,
    input  logic              push_ready,
    output logic              commit,
    output logic              clear_err,
    output logic              start,
    output logic              dbg_req,
    output cmd_pkg::cmd_idx_t dbg_idx,
    output logic              dbg_half,
    input  logic              dbg_done,
    input  bus_pkg::bus_data_t dbg_data,
    input  cmd_pkg::cmd_cnt_t count,
    input  logic              committed,
    input  logic              error,
    input  logic              busy
);
    import bus_pkg::*;

    typedef enum logic [1:0] {IDLE, STATUS_RD, DBG_WAIT} state_e;

    state_e    state;
    bus_data_t rd_q;                           // Registered non-debug read word
    status_t   status;
    logic      wr_acc;
    logic      rd_acc;
    logic      is_dbg;
    logic      ctrl_wr;

    // Writes wait on a pending store and reads wait for their response
    assign bus_ready = (state == IDLE) && (push_ready || !bus_req.write);
    assign wr_acc    = bus_req.valid && bus_ready && bus_req.write;
    assign rd_acc    = bus_req.valid && bus_ready && !bus_req.write;
    assign is_dbg    = bus_req.addr[9:8] == DBG_BASE[9:8];
    assign ctrl_wr   = wr_acc && (bus_req.addr == CTRL_ADDR);

    assign push      = wr_acc && (bus_req.addr == PUSH_ADDR);
    assign push_word = bus_req.wdata;
    assign commit    = ctrl_wr && bus_req.wdata[CTRL_COMMIT];
    assign start     = ctrl_wr && bus_req.wdata[CTRL_START];
    assign clear_err = ctrl_wr && bus_req.wdata[CTRL_CLR_ERR];

    assign dbg_req   = rd_acc && is_dbg;
    assign dbg_idx   = bus_req.addr[7:1];      // Two words per slot
    assign dbg_half  = bus_req.addr[0];        // 1 selects bits 63..32

    assign status = '{rsvd: '0, error: error, busy: busy, committed: committed, count: count};

    assign bus_rsp.rvalid = (state == STATUS_RD) || ((state == DBG_WAIT) && dbg_done);
    assign bus_rsp.rdata  = (state == DBG_WAIT) ? dbg_data : rd_q;

    // ------------------------------------------------------------
    // Outstanding read tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (rd_acc) state <= is_dbg ? DBG_WAIT : STATUS_RD;
                STATUS_RD: state <= IDLE;      // Response shown this cycle
                DBG_WAIT:  if (dbg_done) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rd_q <= (bus_req.addr == STATUS_ADDR) ? status : '0; // Unmapped reads as zero
        end
    end

    // Debug data only comes back for a debug read in flight
    a_no_dbg_done_idle: assert property (@(posedge clk) disable iff (!rst_n)
        (state != DBG_WAIT) |-> !dbg_done);

endmodule

// File: hw/cmd_debug_reader.sv
// Debug read-back, fetches one stored command through the arbiter and returns one 32-bit half
module cmd_debug_reader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               dbg_req,
    input  cmd_pkg::cmd_idx_t  dbg_idx,
    input  logic               dbg_half,
    output cmd_pkg::mem_req_t  mem_req,
    input  logic               mem_gnt,
    input  cmd_pkg::mem_rsp_t  mem_rsp,
    output logic               dbg_done,
    output bus_pkg::bus_data_t dbg_data
);
    import cmd_pkg::*;

    logic     pending;                         // Asking for the memory
    logic     waiting;                         // Granted, data due next cycle
    cmd_idx_t idx_q;
    logic     half_q;

    assign mem_req  = '{valid: pending, write: 1'b0, idx: idx_q, wdata: '0};
    assign dbg_done = waiting && mem_rsp.rvalid;
    assign dbg_data = half_q ? mem_rsp.rdata[63:32] : mem_rsp.rdata[31:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
            waiting <= 1'b0;
        end else begin
            if (dbg_req) pending <= 1'b1;
            if (pending && mem_gnt) begin
                pending <= 1'b0;
                waiting <= 1'b1;
            end
            if (dbg_done) waiting <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dbg_req) begin
            idx_q  <= dbg_idx;
            half_q <= dbg_half;
        end
    end

endmodule

// File: hw/cmd_loader.sv
// Assembles two-word commands from the bus, checks list order and stores them through the arbiter
module cmd_loader (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  bus_pkg::bus_data_t push_word,
    output logic               push_ready,
    input  logic               commit,
    input  logic               clear_err,
    input  logic               busy,
    output cmd_pkg::mem_req_t  mem_req,
    input  logic               mem_gnt,
    output cmd_pkg::cmd_cnt_t  count,
    output logic               committed,
    output logic               error
);
    import cmd_pkg::*;

    logic        phase;                        // 1 when data word is held
    logic [31:0] data_q;                       // First word of the pending command
    cmd_t        cmd_q;                        // Command waiting for a store grant
    logic        wr_pending;
    cmd_op_e     last_op;                      // Op of the newest stored command
    cmd_op_e     push_op;
    logic        push_bad;

    assign push_op    = cmd_op_e'(push_word[1:0]);
    assign push_bad   = busy || (count == cmd_cnt_t'(CMD_DEPTH)); // Locked or full
    assign push_ready = !wr_pending;

    assign mem_req = '{valid: wr_pending, write: 1'b1, idx: count[6:0], wdata: cmd_q};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase      <= 1'b0;
            wr_pending <= 1'b0;
            last_op    <= OP_WRITE;
            count      <= '0;
            committed  <= 1'b0;
            error      <= 1'b0;
        end else begin
            if (clear_err) error <= 1'b0;
            if (wr_pending && mem_gnt) begin   // Slot written, advance
                wr_pending <= 1'b0;
                count      <= count + 8'd1;
            end
            if (push) begin
                if (push_bad) begin
                    error <= 1'b1;             // Word ignored
                end else begin
                    committed <= 1'b0;         // List reopened
                    if (!phase) begin
                        phase <= 1'b1;
                    end else begin
                        phase <= 1'b0;
                        if (push_op inside {OP_RSVD2, OP_RSVD3}) begin
                            error <= 1'b1;     // Pending command dropped
                        end else begin
                            wr_pending <= 1'b1;
                            last_op    <= push_op;
                        end
                    end
                end
            end
            if (commit) begin
                phase <= 1'b0;
                if (count != '0 && last_op == OP_WRITE) begin
                    committed <= 1'b1;
                end else begin
                    count <= '0;               // List discarded
                    error <= 1'b1;
                end
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (push && !push_bad && !phase) data_q <= push_word;
        if (push && !push_bad && phase) begin
            cmd_q <= '{target_addr: push_word[31:2], data: data_q, op: push_op};
        end
    end

    a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
        count <= cmd_cnt_t'(CMD_DEPTH));

endmodule

// File: hw/cmd_mem_arbiter.sv
// Round-robin arbiter giving loader, debug reader and sequencer turns on the single memory port
module cmd_mem_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  cmd_pkg::mem_req_t req_load,
    input  cmd_pkg::mem_req_t req_dbg,
    input  cmd_pkg::mem_req_t req_seq,
    output logic              gnt_load,
    output logic              gnt_dbg,
    output logic              gnt_seq,
    output cmd_pkg::mem_rsp_t rsp_load,
    output cmd_pkg::mem_rsp_t rsp_dbg,
    output cmd_pkg::mem_rsp_t rsp_seq,
    output cmd_pkg::mem_req_t store_req,
    input  cmd_pkg::mem_rsp_t store_rsp
);
    import cmd_pkg::*;

    mem_req_t   reqs [3];                      // 0 load, 1 debug, 2 sequencer
    logic [2:0] gnt;
    logic [2:0] last_gnt;                      // Owner of the read now returning
    logic [1:0] ptr;                           // Highest-priority requester
    logic [1:0] winner;
    logic [1:0] cand;
    logic [2:0] sum;

    assign reqs[0] = req_load;
    assign reqs[1] = req_dbg;
    assign reqs[2] = req_seq;

    // Scan from lowest priority up so the nearest valid requester wins
    always_comb begin
        gnt    = '0;
        winner = ptr;
        cand   = ptr;
        sum    = '0;
        for (int i = 2; i >= 0; i--) begin
            sum  = {1'b0, ptr} + 3'(i);
            cand = (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
            if (reqs[cand].valid) winner = cand;
        end
        if (req_load.valid || req_dbg.valid || req_seq.valid) gnt[winner] = 1'b1;
    end

    assign {gnt_seq, gnt_dbg, gnt_load} = gnt;
    assign store_req = (gnt != '0) ? reqs[winner] : '0;

    assign rsp_load = '{rvalid: store_rsp.rvalid && last_gnt[0], rdata: store_rsp.rdata};
    assign rsp_dbg  = '{rvalid: store_rsp.rvalid && last_gnt[1], rdata: store_rsp.rdata};
    assign rsp_seq  = '{rvalid: store_rsp.rvalid && last_gnt[2], rdata: store_rsp.rdata};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr      <= '0;
            last_gnt <= '0;
        end else begin
            last_gnt <= gnt;
            if (gnt != '0) ptr <= (winner == 2'd2) ? 2'd0 : winner + 2'd1; // Rotate past winner
        end
    end

    // Read data from the store always has exactly one owner to steer to
    a_rsp_owner: assert property (@(posedge clk) disable iff (!rst_n)
        store_rsp.rvalid |-> $onehot(last_gnt));

endmodule

// File: hw/cmd_pkg.sv
// Command format, opcodes, memory sizing and memory-port structs shared by the buffer RTL
package cmd_pkg;

    localparam int CMD_DEPTH = 128;            // Command slots in the store

    typedef logic [6:0] cmd_idx_t;             // Slot index
    typedef logic [7:0] cmd_cnt_t;             // Command count, 0 to CMD_DEPTH

    typedef enum logic [1:0] {
        OP_WRITE = 2'd0,                       // Plain write, legal list terminator
        OP_RWM   = 2'd1,                       // Read-modify-write
        OP_RSVD2 = 2'd2,                       // Reserved, rejected by loader
        OP_RSVD3 = 2'd3                        // Reserved, rejected by loader
    } cmd_op_e;

    // 64-bit command, second bus word on top and data word in the middle
    typedef struct packed {
        logic [29:0] target_addr;              // Bits 63..34
        logic [31:0] data;                     // Bits 33..2
        cmd_op_e     op;                       // Bits 1..0
    } cmd_t;

    typedef struct packed {
        logic     valid;                       // Request present
        logic     write;                       // 1 write, 0 read
        cmd_idx_t idx;                         // Slot
        cmd_t     wdata;                       // Write payload
    } mem_req_t;

    typedef struct packed {
        logic rvalid;                          // Read data valid
        cmd_t rdata;                           // Read payload
    } mem_rsp_t;

endpackage

// File: hw/cmd_sequencer.sv
// Walks the committed list in order and issues each command to the executor under credit control
module cmd_sequencer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              committed,
    input  cmd_pkg::cmd_cnt_t count,
    output cmd_pkg::mem_req_t mem_req,
    input  logic              mem_gnt,
    input  cmd_pkg::mem_rsp_t mem_rsp,
    output logic              exec_valid,
    output cmd_pkg::cmd_t     exec_cmd,
    input  logic              credit_return,
    output logic              busy
);
    import cmd_pkg::*;
    import bus_pkg::*;

    typedef enum logic [1:0] {IDLE, FETCH, WAIT_DATA, ISSUE} state_e;

    state_e   state;
    cmd_cnt_t idx_q;                           // Next slot to run
    cmd_t     cmd_q;                           // Fetched command
    credit_t  credits;

    assign mem_req    = '{valid: state == FETCH, write: 1'b0, idx: idx_q[6:0], wdata: '0};
    assign exec_valid = (state == ISSUE) && (credits != '0); // Waits on zero credits
    assign exec_cmd   = cmd_q;
    assign busy       = state != IDLE;

    // ------------------------------------------------------------
    // Fetch and issue FSM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            idx_q <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start && committed) begin
                        idx_q <= '0;
                        state <= FETCH;
                    end
                end
                FETCH:     if (mem_gnt) state <= WAIT_DATA;
                WAIT_DATA: if (mem_rsp.rvalid) state <= ISSUE;
                ISSUE: begin
                    if (exec_valid) begin
                        idx_q <= idx_q + 8'd1;
                        state <= (idx_q + 8'd1 == count) ? IDLE : FETCH; // Last slot ends run
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == WAIT_DATA && mem_rsp.rvalid) cmd_q <= mem_rsp.rdata;
    end

    // Spend on issue and refill on return
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits <= EXEC_CREDITS;
        end else begin
            credits <= credits - credit_t'(exec_valid) + credit_t'(credit_return);
        end
    end

    // Every issue is followed by a fresh fetch, never back to back
    a_issue_spacing: assert property (@(posedge clk) disable iff (!rst_n)
        exec_valid |=> !exec_valid);
    a_no_extra_credit: assert property (@(posedge clk) disable iff (!rst_n)
        credit_return |-> credits != EXEC_CREDITS);

endmodule

// File: hw/cmd_store.sv
// Single-port command memory, write on the request cycle and registered read one cycle later
module cmd_store (
    input  logic              clk,
    input  logic              rst_n,
    input  cmd_pkg::mem_req_t req,
    output cmd_pkg::mem_rsp_t rsp
);
    import cmd_pkg::*;

    cmd_t mem [CMD_DEPTH];                     // 128 x 64 bits
    logic rvalid_q;
    cmd_t rdata_q;

    assign rsp = '{rvalid: rvalid_q, rdata: rdata_q};

    always_ff @(posedge clk) begin
        if (req.valid && req.write) mem[req.idx] <= req.wdata;
        if (req.valid && !req.write) rdata_q <= mem[req.idx];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) rvalid_q <= 1'b0;
        else        rvalid_q <= req.valid && !req.write;
    end

endmodule

// File: testbench/tb_cmd_buffer.sv
// Directed testbench for the command buffer, simulation top with bus driver and executor model
module tb_cmd_buffer;
    import cmd_pkg::*;
    import bus_pkg::*;

    localparam int PERIOD       = 40;
    localparam int DRIVE_DELAY  = 2;               // Input skew after rising edge
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 200;             // Cycles allowed per handshake
    localparam int XFER_EST     = 450;             // Bus transfers over all tests
    localparam int XFER_CYCLES  = 6;               // Worst cycles per transfer
    localparam int MARGIN       = 4;
    localparam int WATCHDOG_CYCLES = (RESET_CYCLES + XFER_EST * XFER_CYCLES + 1000) * MARGIN;
    localparam logic [31:0] SEED = 32'hebf2_e653;

    logic     clk = 1'b0;
    logic     rst_n;
    bus_req_t bus_req;
    logic     bus_ready;
    bus_rsp_t bus_rsp;
    logic     exec_valid;
    cmd_t     exec_cmd;
    logic     credit_return;

    logic [63:0] exp_list [$];                     // Commands the list should hold
    logic [63:0] exec_log [$];                     // All commands seen by executor
    int          returned;                         // Credits handed back so far
    logic        hold_credits;                     // Executor withholds credits
    int          checks;
    int          errors;

    cmd_buffer_top cmd_buffer_top_i (
        .clk, .rst_n, .bus_req, .bus_ready, .bus_rsp,
        .exec_valid, .exec_cmd, .credit_return
    );

    always #(PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------
    // Executor model
    always @(negedge clk) begin
        if (rst_n === 1'b1 && exec_valid === 1'b1) exec_log.push_back(exec_cmd);
    end

    initial begin
        int delay;
        credit_return = 1'b0;
        returned      = 0;
        delay         = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY;
            credit_return = 1'b0;
            if (!hold_credits && exec_log.size() > returned) begin
                if (delay == 0) begin
                    credit_return = 1'b1;          // One credit per pulse
                    returned++;
                    delay = $urandom_range(3, 0);
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Verification failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Checking and reference helpers
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR t=%0t %s", $time, msg);
    endtask

    function automatic bus_data_t status_word(input int cnt, input logic cmt,
                                              input logic bsy, input logic err);
        return {21'd0, err, bsy, cmt, 8'(cnt)};    // Bits 10, 9, 8 and count
    endfunction

    task automatic end_test(input string name, input int err0);
        $display("Test %s done, %0d errors", name, errors - err0);
    endtask

    // ------------------------------------------------------------
    // Bus driver
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge clk);
        while (!bus_ready && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (!bus_ready) report_error("bus_ready stayed low, transfer not accepted");
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        @(posedge clk);
        #DRIVE_DELAY;
        bus_req.valid = 1'b1;
        bus_req.write = 1'b1;
        bus_req.addr  = addr;
        bus_req.wdata = data;
        wait_ready();
        @(posedge clk);                            // Accepted on this edge
        #DRIVE_DELAY;
        bus_req.valid = 1'b0;
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        int n;
        @(posedge clk);
        #DRIVE_DELAY;
        bus_req.valid = 1'b1;
        bus_req.write = 1'b0;
        bus_req.addr  = addr;
        bus_req.wdata = '0;
        wait_ready();
        @(posedge clk);
        #DRIVE_DELAY;
        bus_req.valid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!bus_rsp.rvalid && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (!bus_rsp.rvalid) report_error("read response never arrived");
        data = bus_rsp.rdata;
    endtask

    task automatic ctrl_write(input int bit_pos);
        bus_write(CTRL_ADDR, bus_data_t'(1) << bit_pos);
    endtask

    task automatic check_status(input string name, input bus_data_t expected);
        bus_data_t s;
        bus_read(STATUS_ADDR, s);
        check_value(name, 64'(s), 64'(expected));
    endtask

    // ------------------------------------------------------------
    // Command list helpers
    task automatic random_cmd(input cmd_op_e op, output bus_data_t w0, output bus_data_t w1);
        w0 = $urandom;                             // Data field
        w1 = $urandom;                             // Target address on top
        w1[1:0] = op;
    endtask

    task automatic push_cmd(input bus_data_t w0, input bus_data_t w1);
        bus_write(PUSH_ADDR, w0);
        bus_write(PUSH_ADDR, w1);
    endtask

    task automatic load_list(input int n);
        bus_data_t w0;
        bus_data_t w1;
        cmd_op_e   op;
        for (int i = 0; i < n; i++) begin
            op = ($urandom_range(1, 0) == 0 || i == n - 1) ? OP_WRITE : OP_RWM;
            random_cmd(op, w0, w1);
            push_cmd(w0, w1);
            exp_list.push_back({w1[31:2], w0, w1[1:0]}); // Layout addr, data, op
        end
        ctrl_write(CTRL_COMMIT);
    endtask

    task automatic discard_list();
        bus_data_t w0;
        bus_data_t w1;
        random_cmd(OP_RWM, w0, w1);                // RWM tail forces rejection
        push_cmd(w0, w1);
        ctrl_write(CTRL_COMMIT);
        ctrl_write(CTRL_CLR_ERR);
        exp_list.delete();
    endtask

    task automatic debug_check(input int idx);
        bus_data_t d;
        for (int h = 0; h < 2; h++) begin
            bus_read(DBG_BASE + bus_addr_t'(2 * idx + h), d);
            check_value($sformatf("dbg[%0d].half%0d", idx, h), 64'(d),
                        64'(h == 0 ? exp_list[idx][31:0] : exp_list[idx][63:32]));
        end
    endtask

    task automatic wait_exec(input int total);
        int n;
        n = 0;
        while (exec_log.size() < total && n < total * 20 + WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (exec_log.size() < total) report_error("executor did not get all commands");
    endtask

    task automatic wait_credits();
        int n;
        n = 0;
        while (returned != exec_log.size() && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (returned != exec_log.size()) report_error("executor credits never came back");
    endtask

    task automatic check_exec(input int base);
        check_value("exec count", 64'(exec_log.size() - base), 64'(exp_list.size()));
        for (int i = 0; i < exp_list.size() && base + i < exec_log.size(); i++) begin
            check_value($sformatf("exec_cmd[%0d]", i), exec_log[base + i], exp_list[i]);
        end
    endtask

    // ------------------------------------------------------------
    // Directed tests
    task automatic test_reset_state();
        int err0;
        err0 = errors;
        check_value("bus_ready", 64'(bus_ready), 64'(1));
        check_value("bus_rsp.rvalid", 64'(bus_rsp.rvalid), 64'(0));
        check_value("exec_valid", 64'(exec_valid), 64'(0));
        check_status("status", status_word(0, 0, 0, 0));
        repeat (10) @(negedge clk);
        check_value("exec count", 64'(exec_log.size()), 64'(0));
        end_test("reset_state", err0);
    endtask

    task automatic test_load_readback();
        int err0;
        err0 = errors;
        load_list(8);
        check_status("status", status_word(8, 1, 0, 0));
        for (int i = 0; i < 8; i++) debug_check(i);
        end_test("load_readback", err0);
    endtask

    task automatic test_sequence_rules();
        int        err0;
        bus_data_t w0;
        bus_data_t w1;
        err0 = errors;
        random_cmd(OP_RWM, w0, w1);
        push_cmd(w0, w1);
        ctrl_write(CTRL_COMMIT);                   // RWM tail, rejected
        check_status("status", status_word(0, 0, 0, 1));
        ctrl_write(CTRL_CLR_ERR);
        check_status("status", status_word(0, 0, 0, 0));
        random_cmd(OP_RSVD2, w0, w1);
        push_cmd(w0, w1);                          // Reserved op dropped
        check_status("status", status_word(0, 0, 0, 1));
        ctrl_write(CTRL_CLR_ERR);
        for (int i = 0; i < CMD_DEPTH; i++) begin
            random_cmd((i == CMD_DEPTH - 1) ? OP_RWM : OP_WRITE, w0, w1);
            push_cmd(w0, w1);
        end
        check_status("status", status_word(CMD_DEPTH, 0, 0, 0));
        random_cmd(OP_WRITE, w0, w1);
        push_cmd(w0, w1);                          // One past full
        check_status("status", status_word(CMD_DEPTH, 0, 0, 1));
        ctrl_write(CTRL_COMMIT);
        check_status("status", status_word(0, 0, 0, 1));
        ctrl_write(CTRL_CLR_ERR);
        check_status("status", status_word(0, 0, 0, 0));
        exp_list.delete();
        end_test("sequence_rules", err0);
    endtask

    task automatic test_execution_order();
        int err0;
        int base;
        err0 = errors;
        base = exec_log.size();
        ctrl_write(CTRL_START);                    // Nothing committed
        repeat (20) @(negedge clk);
        check_value("exec count", 64'(exec_log.size() - base), 64'(0));
        check_status("status", status_word(0, 0, 0, 0));
        load_list(10);
        base = exec_log.size();
        ctrl_write(CTRL_START);
        wait_exec(base + 10);
        check_status("status", status_word(10, 1, 0, 0));
        check_exec(base);
        end_test("execution_order", err0);
    endtask

    task automatic test_credit_backpressure();
        int err0;
        int base;
        err0 = errors;
        discard_list();
        load_list(10);
        wait_credits();
        hold_credits = 1'b1;
        base = exec_log.size();
        ctrl_write(CTRL_START);
        wait_exec(base + int'(EXEC_CREDITS));
        repeat (40) @(negedge clk);                // Time to overrun if broken
        check_value("exec count while held", 64'(exec_log.size() - base), 64'(EXEC_CREDITS));
        hold_credits = 1'b0;
        wait_exec(base + 10);
        check_exec(base);
        end_test("credit_backpressure", err0);
    endtask

    task automatic test_access_during_run();
        int        err0;
        int        base;
        bus_data_t w0;
        bus_data_t w1;
        err0 = errors;
        discard_list();
        load_list(12);
        wait_credits();
        hold_credits = 1'b1;                       // Keeps sequencer busy
        base = exec_log.size();
        ctrl_write(CTRL_START);
        for (int i = 0; i < 12; i++) debug_check(i);
        random_cmd(OP_WRITE, w0, w1);
        push_cmd(w0, w1);                          // Refused while busy
        check_status("status", status_word(12, 1, 1, 1));
        hold_credits = 1'b0;
        debug_check(0);
        debug_check(11);
        wait_exec(base + 12);
        check_exec(base);
        check_status("status", status_word(12, 1, 0, 1));
        end_test("access_during_run", err0);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    initial begin
        void'($urandom(SEED));
        checks       = 0;
        errors       = 0;
        hold_credits = 1'b0;
        rst_n        = 1'b0;
        bus_req      = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        test_reset_state();
        test_load_readback();
        test_sequence_rules();
        test_execution_order();
        test_credit_backpressure();
        test_access_during_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
